// ==== Makefile ====
# Verilator build and run of the board register subsystem testbench.
# Override any variable on the command line, e.g. make run LOG=run1.log

VERILATOR ?= verilator
TOP       ?= tb_board_ctrl
FILELIST  ?= filelist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

SIM_BIN = $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	@./$(SIM_BIN) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "STATUS: FAIL" $(LOG); then \
		echo "simulation reported failure, see $(LOG)"; exit 1; \
	fi
	@if ! grep -q "STATUS: PASS" $(LOG); then \
		echo "simulation ended without a result, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== filelist.f ====
+incdir+include
hdl/board_pkg.sv
hdl/wdog_timer.sv
hdl/mv_power_seq.sv
hdl/board_regs.sv
hdl/board_ctrl_top.sv
verification/board_ctrl_sva.sv
verification/tb_board_ctrl.sv

// ==== hdl/board_ctrl_top.sv ====
// Board register subsystem top level.
// TICK_WIDTH sets the watchdog and settle tick rate, SETTLE_TICKS
// the motor-supply settle time in ticks. Wiring only.

`timescale 1ns/1ns
`default_nettype none

module board_ctrl_top
    import board_pkg::*;
#(
    parameter int TICK_WIDTH   = 8,
    parameter int SETTLE_TICKS = 7680
) (
    input  logic         sysclk,
    input  logic         rst_n,
    // host register bus
    input  reg_addr_t    reg_raddr,
    input  reg_addr_t    reg_waddr,
    input  reg_data_t    reg_wdata,
    input  logic         reg_wen,
    output reg_data_t    reg_rdata,
    // board inputs
    input  axis_inputs_t axis_in,
    input  board_id_t    board_id,
    input  temp_t        temp_sense,
    input  logic         relay,
    input  logic         mv_faultn,
    input  logic         mv_good,
    input  axis_mask_t   safety_amp_disable,
    // board outputs
    output axis_mask_t   amp_disable,
    output logic         pwr_enable,
    output logic         relay_on,
    output logic         reboot,
    output reg_data_t    debug,
    output logic         wdog_timeout
);

    // ----------------------------------------
    // internal nets
    // ----------------------------------------
    logic         powerup_cmd;
    logic         tick;          // shared slow tick
    wdog_period_t wdog_period;
    axis_mask_t   mv_hold;

    board_regs u_regs (
        .sysclk             (sysclk),
        .rst_n              (rst_n),
        .reg_raddr          (reg_raddr),
        .reg_waddr          (reg_waddr),
        .reg_wdata          (reg_wdata),
        .reg_wen            (reg_wen),
        .reg_rdata          (reg_rdata),
        .axis_in            (axis_in),
        .board_id           (board_id),
        .temp_sense         (temp_sense),
        .relay              (relay),
        .mv_faultn          (mv_faultn),
        .mv_good            (mv_good),
        .safety_amp_disable (safety_amp_disable),
        .wdog_timeout       (wdog_timeout),
        .mv_hold            (mv_hold),
        .powerup_cmd        (powerup_cmd),
        .wdog_period        (wdog_period),
        .amp_disable        (amp_disable),
        .pwr_enable         (pwr_enable),
        .relay_on           (relay_on),
        .reboot             (reboot),
        .debug              (debug)
    );

    wdog_timer #(
        .TICK_WIDTH (TICK_WIDTH)
    ) u_wdog (
        .sysclk       (sysclk),
        .rst_n        (rst_n),
        .kick         (reg_wen),      // every host write counts as activity
        .powerup_cmd  (powerup_cmd),
        .wdog_period  (wdog_period),
        .tick         (tick),
        .wdog_timeout (wdog_timeout)
    );

    mv_power_seq #(
        .SETTLE_TICKS (SETTLE_TICKS)
    ) u_mv_seq (
        .sysclk  (sysclk),
        .rst_n   (rst_n),
        .tick    (tick),
        .mv_good (mv_good),
        .mv_hold (mv_hold)
    );

endmodule : board_ctrl_top

`default_nettype wire

// ==== hdl/board_pkg.sv ====
// Shared types and constants for the board register block.
// Axis masks are 4 bits wide, bit 0 is axis 1.
// Widths here are fixed for a four-axis board. Other axis counts
// need new packing in the status and digital input words.

`default_nettype none

package board_pkg;

    // ----------------------------------------
    // bus and data widths
    // ----------------------------------------
    typedef logic [15:0] reg_addr_t;     // host register address
    typedef logic [31:0] reg_data_t;     // host register data word

    // ----------------------------------------
    // board-level quantities
    // ----------------------------------------
    typedef logic [3:0]  axis_mask_t;    // one bit per axis
    typedef logic [15:0] wdog_period_t;  // watchdog period, in ticks
    typedef logic [3:0]  board_id_t;     // rotary switch
    typedef logic [15:0] temp_t;         // raw sensor reading

    // axis digital inputs, grouped per signal kind
    // enc_a sits in the top bits
    typedef struct packed {
        axis_mask_t enc_a;       // encoder channel a
        axis_mask_t enc_b;       // encoder channel b
        axis_mask_t enc_i;       // encoder index
        axis_mask_t neg_limit;   // negative limit switch
        axis_mask_t pos_limit;   // positive limit switch
        axis_mask_t home;        // home switch
        axis_mask_t fault;       // amplifier fault, 1 = amp ok
    } axis_inputs_t;

    // motor supply sequencing
    typedef enum logic [1:0] {
        MV_OFF,      // supply absent, amps held
        MV_SETTLE,   // supply good, waiting out settle time
        MV_READY     // amps released
    } mv_state_t;

    // ----------------------------------------
    // constants
    // ----------------------------------------
    localparam int NUM_AXES = 4;                       // reported in status[31:28]

    // about 30 ms at the full-rate tick
    localparam wdog_period_t WDOG_PERIOD_RST = 16'h1680;

    localparam reg_data_t DEBUG_RST = 32'h0000_2000;   // debug word after reset

endpackage : board_pkg

`default_nettype wire

// ==== hdl/board_regs.sv ====
// Main-bank register file of the board.
// Writes take effect on the edge that samples reg_wen, reads are
// registered with one cycle of latency and hold during write cycles.
// Only address bits 3:0 select the read register.
// Disable bits latch watchdog and safety shutdowns until the host
// re-enables the axis.

`timescale 1ns/1ns
`default_nettype none

`include "board_regmap.svh"

module board_regs
    import board_pkg::*;
(
    input  logic         sysclk,
    input  logic         rst_n,
    // host register bus
    input  reg_addr_t    reg_raddr,
    input  reg_addr_t    reg_waddr,
    input  reg_data_t    reg_wdata,
    input  logic         reg_wen,
    output reg_data_t    reg_rdata,
    // board inputs
    input  axis_inputs_t axis_in,
    input  board_id_t    board_id,
    input  temp_t        temp_sense,
    input  logic         relay,               // relay state feedback
    input  logic         mv_faultn,           // motor supply fault, active low
    input  logic         mv_good,             // motor supply good
    input  axis_mask_t   safety_amp_disable,
    input  logic         wdog_timeout,
    input  axis_mask_t   mv_hold,             // settle hold from supply sequencer
    // control outputs
    output logic         powerup_cmd,
    output wdog_period_t wdog_period,
    output axis_mask_t   amp_disable,
    output logic         pwr_enable,
    output logic         relay_on,
    output logic         reboot,
    output reg_data_t    debug
);

    // ----------------------------------------
    // write decode
    // ----------------------------------------
    logic       write_main;     // write into main bank
    logic       write_status;
    logic       pwr_en_cmd;     // host asks for board power
    axis_mask_t amp_en_cmd;     // host asks for amp enable, per axis
    axis_mask_t disable_q;      // latched amp disables
    axis_mask_t disable_wr;     // disable value for a status write
    reg_data_t  status_word;
    reg_data_t  digin_word;
    reg_data_t  rd_mux;

    assign write_main   = reg_wen && (reg_waddr[15:12] == `ADDR_MAIN)
                          && (reg_waddr[7:4] == 4'd0);
    assign write_status = write_main && (reg_waddr[3:0] == `REG_STATUS);

    assign pwr_en_cmd  = write_status && reg_wdata[19] && reg_wdata[18];
    assign amp_en_cmd  = write_status ? (reg_wdata[11:8] & reg_wdata[3:0]) : '0;
    assign powerup_cmd = pwr_en_cmd || (|amp_en_cmd);  // clears watchdog timeout

    // masked enable per axis, forced off while board power is off
    // mask set -> take ~enable bit, else keep
    assign disable_wr = {4{~pwr_enable}}
                      | (reg_wdata[11:8] & ~reg_wdata[3:0])
                      | (~reg_wdata[11:8] & disable_q);

    assign amp_disable = disable_q | mv_hold;   // settle hold overrides register state

    // ----------------------------------------
    // read words
    // ----------------------------------------
    assign status_word = {
        4'(NUM_AXES), board_id,                  // 31:24
        wdog_timeout, 3'd0,                      // 23:20
        mv_good, pwr_enable, ~relay, relay_on,   // 19:16
        ~mv_faultn, 3'd0,                        // 15:12
        axis_in.fault,                           // 11:8, 1 = amp ok
        safety_amp_disable,                      // 7:4
        ~disable_q                               // 3:0, 1 = amp enabled
    };

    assign digin_word = {
        4'd0,
        axis_in.enc_a, axis_in.enc_b, axis_in.enc_i,
        4'd0,
        axis_in.neg_limit, axis_in.pos_limit, axis_in.home
    };

    always_comb begin
        case (reg_raddr[3:0])
            `REG_STATUS:   rd_mux = status_word;
            `REG_TIMEOUT:  rd_mux = {16'd0, wdog_period};
            `REG_VERSION:  rd_mux = `VERSION;
            `REG_TEMPSNS:  rd_mux = {16'd0, temp_sense};
            `REG_FVERSION: rd_mux = `FW_VERSION;
            `REG_DIGIN:    rd_mux = digin_word;
            `REG_DEBUG:    rd_mux = debug;
            default:       rd_mux = '0;      // unmapped offsets
        endcase
    end

    // ----------------------------------------
    // register file
    // ----------------------------------------
    always_ff @(posedge sysclk or negedge rst_n) begin
        if (!rst_n) begin
            disable_q   <= '1;               // all amps off at start-up
            pwr_enable  <= 1'b0;
            relay_on    <= 1'b0;
            reboot      <= 1'b0;
            wdog_period <= WDOG_PERIOD_RST;
            debug       <= DEBUG_RST;
            reg_rdata   <= '0;
        end else if (reg_wen) begin
            // read data holds during any write cycle
            if (write_main) begin
                case (reg_waddr[3:0])
                    `REG_STATUS: begin
                        disable_q <= disable_wr;
                        if (reg_wdata[19])
                            pwr_enable <= reg_wdata[18];
                        if (reg_wdata[17])
                            relay_on <= reg_wdata[16];
                        reboot <= reg_wdata[21] ? reg_wdata[20] : 1'b0;  // unmasked write clears
                    end
                    `REG_TIMEOUT: wdog_period <= reg_wdata[15:0];
                    `REG_DEBUG:   debug       <= reg_wdata;
                    default: ;                   // read-only or unmapped
                endcase
            end
        end else begin
            reg_rdata <= rd_mux;
            // watchdog shuts every axis, safety only the flagged ones
            disable_q <= disable_q | (wdog_timeout ? 4'hf : safety_amp_disable);
        end
    end

endmodule : board_regs

`default_nettype wire

// ==== hdl/mv_power_seq.sv ====
// Motor-supply settle sequencer.
// Amplifiers are held off until mv_good has stayed high for
// SETTLE_TICKS ticks, and held again on the edge after it drops.
// mv_good is taken as already synchronous to sysclk.

`timescale 1ns/1ns
`default_nettype none

module mv_power_seq
    import board_pkg::*;
#(
    parameter int SETTLE_TICKS = 7680   // 40 ms at the full-rate tick
) (
    input  logic       sysclk,
    input  logic       rst_n,
    input  logic       tick,
    input  logic       mv_good,
    output axis_mask_t mv_hold
);

    localparam int CNT_W = $clog2(SETTLE_TICKS + 1);

    mv_state_t        state;
    logic [CNT_W-1:0] settle_cnt;   // ticks seen in MV_SETTLE

    // ----------------------------------------
    // state machine
    // ----------------------------------------
    always_ff @(posedge sysclk or negedge rst_n) begin
        if (!rst_n) begin
            state      <= MV_OFF;
            settle_cnt <= '0;
        end else if (!mv_good) begin
            // supply lost, drop back immediately
            state      <= MV_OFF;
            settle_cnt <= '0;
        end else begin
            case (state)
                MV_OFF: begin
                    state      <= MV_SETTLE;
                    settle_cnt <= '0;
                end
                MV_SETTLE: begin
                    if (tick) begin
                        if (settle_cnt == CNT_W'(SETTLE_TICKS - 1))
                            state <= MV_READY;    // last settle tick
                        else
                            settle_cnt <= settle_cnt + 1'b1;
                    end
                end
                MV_READY: ;                       // stay while supply good
                default:  state <= MV_OFF;
            endcase
        end
    end

    assign mv_hold = (state == MV_READY) ? 4'h0 : 4'hf;

endmodule : mv_power_seq

`default_nettype wire

// ==== hdl/wdog_timer.sv ====
// Tick prescaler and host-activity watchdog.
// tick is one sysclk cycle wide, once every 2**TICK_WIDTH cycles.
// Timeout sets period+1 to period+2 ticks after the last kick and
// stays set until a power-up command. A period of 0 disables it.

`timescale 1ns/1ns
`default_nettype none

module wdog_timer
    import board_pkg::*;
#(
    parameter int TICK_WIDTH = 8
) (
    input  logic         sysclk,
    input  logic         rst_n,
    input  logic         kick,          // any host write
    input  logic         powerup_cmd,
    input  wdog_period_t wdog_period,
    output logic         tick,
    output logic         wdog_timeout
);

    // ----------------------------------------
    // prescaler
    // ----------------------------------------
    logic [TICK_WIDTH-1:0] presc_q;
    wdog_period_t          wdog_count;

    always_ff @(posedge sysclk or negedge rst_n) begin
        if (!rst_n)
            presc_q <= '0;
        else
            presc_q <= presc_q + 1'b1;   // free running, wraps
    end

    assign tick = &presc_q;   // last count of each prescaler lap

    // ----------------------------------------
    // watchdog counter
    // ----------------------------------------
    always_ff @(posedge sysclk or negedge rst_n) begin
        if (!rst_n) begin
            wdog_count   <= '0;
            wdog_timeout <= 1'b0;
        end else if (powerup_cmd) begin
            // host powering up, restart from clean state
            wdog_count   <= '0;
            wdog_timeout <= 1'b0;
        end else if (kick) begin
            wdog_count <= '0;                     // host alive, timeout stays as is
        end else if (tick && (wdog_period != '0)) begin
            if (wdog_count < wdog_period)
                wdog_count <= wdog_count + 1'b1;
            else
                wdog_timeout <= 1'b1;             // sticky
        end
    end

endmodule : wdog_timer

`default_nettype wire

// ==== include/board_regmap.svh ====
// Main-bank register map of the board register block.
// Offsets are 4-bit values compared against address bits 3:0.
// Only the main bank is decoded here.

`ifndef BOARD_REGMAP_SVH
`define BOARD_REGMAP_SVH

// bank select, address bits 15:12
`define ADDR_MAIN    4'h0

// main-bank offsets
`define REG_STATUS   4'd0   // board status and control
`define REG_TIMEOUT  4'd3   // watchdog period
`define REG_VERSION  4'd4   // fixed board word
`define REG_TEMPSNS  4'd5   // temperature sensor
`define REG_FVERSION 4'd7   // firmware version
`define REG_DIGIN    4'd10  // axis digital inputs
`define REG_DEBUG    4'd15  // scratch / debug word

// identification words
`define VERSION      32'h514C_4131   // "QLA1"
`define FW_VERSION   32'd8

`endif // BOARD_REGMAP_SVH

// ==== verification/board_ctrl_sva.sv ====
// Assertions on the register block shutdown and read rules.
// Bound into board_regs, sampled on the rising sysclk edge.
// Checks are off while rst_n is low.

`timescale 1ns/1ns
`default_nettype none

module board_ctrl_sva
    import board_pkg::*;
(
    input logic       sysclk,
    input logic       rst_n,
    input logic       reg_wen,
    input reg_data_t  reg_rdata,
    input logic       wdog_timeout,
    input logic       powerup_cmd,
    input axis_mask_t amp_disable
);

    // ----------------------------------------
    // watchdog shutdown
    // ----------------------------------------
    wdog_disables_all: assert property (@(posedge sysclk) disable iff (!rst_n)
        (wdog_timeout && !reg_wen) |=> (amp_disable == 4'hf))
        else $error("amp_disable not all ones after a watchdog timeout cycle");

    // only a power-up command clears the timeout
    timeout_sticky: assert property (@(posedge sysclk) disable iff (!rst_n)
        $fell(wdog_timeout) |-> $past(powerup_cmd))
        else $error("wdog_timeout fell without powerup_cmd");

    // read data holds through writes
    rdata_hold: assert property (@(posedge sysclk) disable iff (!rst_n)
        reg_wen |=> $stable(reg_rdata))
        else $error("reg_rdata changed during a write cycle");

endmodule : board_ctrl_sva

bind board_regs board_ctrl_sva u_sva (
    .sysclk       (sysclk),
    .rst_n        (rst_n),
    .reg_wen      (reg_wen),
    .reg_rdata    (reg_rdata),
    .wdog_timeout (wdog_timeout),
    .powerup_cmd  (powerup_cmd),
    .amp_disable  (amp_disable)
);

`default_nettype wire

// ==== verification/tb_board_ctrl.sv ====
// Directed testbench for the board register subsystem.
// Built with a fast tick (TICK_WIDTH 2) and a short settle (6 ticks).
// Inputs change on the falling clock edge and outputs are sampled there.
// Board inputs are random from a fixed seed and stay put after reset.

`timescale 1ns/1ns
`default_nettype none

`include "board_regmap.svh"

module tb_board_ctrl
    import board_pkg::*;
();

    localparam int TICK_WIDTH   = 2;
    localparam int SETTLE_TICKS = 6;
    localparam int CLK_NS       = 100;
    localparam int TICK_CYC     = 1 << TICK_WIDTH;   // sysclk cycles per tick
    // cycle budget summed over the tests
    localparam int RUN_CYC = 10 + 60 + 80
                           + 3 * (SETTLE_TICKS + 3) * TICK_CYC + 40
                           + 8 * TICK_CYC + 40
                           + 10 * (2 * TICK_CYC + 2) + 40 * TICK_CYC + 40
                           + 40;

    // status write fields with the mask bit above the value bit
    localparam reg_data_t PWR_ON     = 32'h000C_0000;
    localparam reg_data_t RELAY_SET  = 32'h0003_0000;
    localparam reg_data_t RELAY_CLR  = 32'h0002_0000;
    localparam reg_data_t REBOOT_SET = 32'h0030_0000;

    logic         sysclk;
    logic         rst_n;
    reg_addr_t    reg_raddr;
    reg_addr_t    reg_waddr;
    reg_data_t    reg_wdata;
    logic         reg_wen;
    reg_data_t    reg_rdata;
    axis_inputs_t axis_in;
    board_id_t    board_id;
    temp_t        temp_sense;
    logic         relay;
    logic         mv_faultn;
    logic         mv_good;
    axis_mask_t   safety_amp_disable;
    axis_mask_t   amp_disable;
    logic         pwr_enable;
    logic         relay_on;
    logic         reboot;
    reg_data_t    debug;
    logic         wdog_timeout;

    // expected state
    axis_mask_t   exp_dis;       // latched disables
    axis_mask_t   exp_hold;      // supply settle hold
    logic         exp_pwr;
    logic         exp_relay;
    logic         exp_reboot;
    logic         exp_timeout;
    int           error_count;

    board_ctrl_top #(
        .TICK_WIDTH   (TICK_WIDTH),
        .SETTLE_TICKS (SETTLE_TICKS)
    ) uut (.*);

    initial begin
        sysclk = 1'b0;
        forever #(CLK_NS / 2) sysclk = ~sysclk;
    end

    // run limit
    initial begin
        #(2 * RUN_CYC * CLK_NS);
        $display("Error: run exceeded %0d cycles before the tests completed", 2 * RUN_CYC);
        $display("STATUS: FAIL");
        $finish;
    end

    // ----------------------------------------
    // compare tasks
    // ----------------------------------------
    task automatic check_data(input string name, input reg_data_t got, input reg_data_t exp);
        if (got !== exp) begin
            error_count = error_count + 1;
            $display("Error at %0t ns: %s = 0x%08h, expected 0x%08h", $time, name, got, exp);
        end
    endtask

    task automatic check_mask(input string name, input axis_mask_t got, input axis_mask_t exp);
        if (got !== exp) begin
            error_count = error_count + 1;
            $display("Error at %0t ns: %s = 0x%h, expected 0x%h", $time, name, got, exp);
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            error_count = error_count + 1;
            $display("Error at %0t ns: %s = %b, expected %b", $time, name, got, exp);
        end
    endtask

    // ----------------------------------------
    // expected words from the register rules
    // ----------------------------------------
    function automatic reg_addr_t reg_addr(input logic [3:0] off);
        return {`ADDR_MAIN, 8'h00, off};   // main bank with bits 7:4 zero
    endfunction

    function automatic reg_data_t amp_word(input axis_mask_t mask, input axis_mask_t en);
        return {20'd0, mask, 4'd0, en};
    endfunction

    function automatic reg_data_t expected_status();
        reg_data_t w;
        w        = '0;
        w[31:28] = 4'(NUM_AXES);
        w[27:24] = board_id;
        w[23]    = exp_timeout;
        w[19]    = mv_good;
        w[18]    = exp_pwr;
        w[17]    = ~relay;
        w[16]    = exp_relay;
        w[15]    = ~mv_faultn;
        w[11:8]  = axis_in.fault;
        w[7:4]   = safety_amp_disable;
        w[3:0]   = ~exp_dis;          // 1 = enabled
        return w;
    endfunction

    function automatic reg_data_t expected_digin();
        reg_data_t w;
        w        = '0;
        w[27:24] = axis_in.enc_a;
        w[23:20] = axis_in.enc_b;
        w[19:16] = axis_in.enc_i;
        w[11:8]  = axis_in.neg_limit;
        w[7:4]   = axis_in.pos_limit;
        w[3:0]   = axis_in.home;
        return w;
    endfunction

    // per-axis disable after a status write
    function automatic axis_mask_t next_disable(input axis_mask_t old, input logic pwr_old,
                                                input reg_data_t d);
        axis_mask_t r;
        int         n;
        r = '0;
        for (n = 0; n < 4; n++) begin
            if (!pwr_old)
                r[n] = 1'b1;        // stays off without board power
            else if (d[n + 8])
                r[n] = ~d[n];
            else
                r[n] = old[n];
        end
        return r;
    endfunction

    // ----------------------------------------
    // bus tasks
    // ----------------------------------------
    task automatic bus_write(input logic [3:0] off, input reg_data_t data);
        @(negedge sysclk);
        reg_waddr = reg_addr(off);
        reg_wdata = data;
        reg_wen   = 1'b1;
        @(negedge sysclk);
        reg_wen   = 1'b0;
    endtask

    task automatic bus_read(input logic [3:0] off, output reg_data_t data);
        @(negedge sysclk);
        reg_raddr = reg_addr(off);
        @(negedge sysclk);
        data = reg_rdata;          // one cycle latency
    endtask

    task automatic read_check(input logic [3:0] off, input reg_data_t exp, input string name);
        reg_data_t got;
        bus_read(off, got);
        check_data(name, got, exp);
    endtask

    // status write plus model update
    task automatic status_write(input reg_data_t d);
        bus_write(`REG_STATUS, d);
        exp_dis = next_disable(exp_dis, exp_pwr, d);
        if (d[19])
            exp_pwr = d[18];
        if (d[17])
            exp_relay = d[16];
        exp_reboot = d[21] & d[20];
        if ((d[19] && d[18]) || (|(d[11:8] & d[3:0])))
            exp_timeout = 1'b0;     // power-up command
    endtask

    task automatic check_controls();
        check_mask("amp_disable", amp_disable, exp_dis | exp_hold);
        check_bit("pwr_enable", pwr_enable, exp_pwr);
        check_bit("relay_on", relay_on, exp_relay);
        check_bit("reboot", reboot, exp_reboot);
        check_bit("wdog_timeout", wdog_timeout, exp_timeout);
    endtask

    // ----------------------------------------
    // directed tests
    // ----------------------------------------
    task automatic test_reset_values();
        reg_data_t rnd;
        check_controls();
        check_data("debug", debug, DEBUG_RST);
        read_check(`REG_TIMEOUT, {16'd0, WDOG_PERIOD_RST}, "TIMEOUT");
        read_check(`REG_DEBUG, DEBUG_RST, "DEBUG");
        read_check(`REG_FVERSION, 32'd8, "FVERSION");
        read_check(`REG_VERSION, `VERSION, "VERSION");
        read_check(`REG_TEMPSNS, {16'd0, temp_sense}, "TEMPSNS");
        read_check(`REG_DIGIN, expected_digin(), "DIGIN");
        read_check(4'd1, 32'd0, "unmapped offset 1");
        read_check(4'd12, 32'd0, "unmapped offset 12");
        rnd = $urandom;
        bus_write(`REG_DEBUG, rnd);
        read_check(`REG_DEBUG, rnd, "DEBUG");
        check_data("debug", debug, rnd);
    endtask

    task automatic test_status_control();
        status_write(amp_word(4'hf, 4'hf));          // ignored while power is off
        check_controls();
        read_check(`REG_STATUS, expected_status(), "STATUS");
        status_write(PWR_ON);
        check_controls();
        status_write(amp_word(4'b0101, 4'b0101));
        status_write(amp_word(4'b0011, 4'b0010));    // axis 1 off, axis 2 on
        check_controls();
        read_check(`REG_STATUS, expected_status(), "STATUS");
        status_write(RELAY_SET | REBOOT_SET);
        check_controls();
        status_write(32'd0);                          // unmasked reboot bit clears it
        check_controls();
        status_write(RELAY_CLR);
        check_controls();
        read_check(`REG_STATUS, expected_status(), "STATUS");
    endtask

    task automatic test_mv_settle();
        int ticks;
        int cycles;
        status_write(amp_word(4'hf, 4'hf));
        mv_good = 1'b1;
        ticks   = 0;
        cycles  = 0;
        while ((amp_disable == 4'hf) && (cycles < (SETTLE_TICKS + 3) * TICK_CYC)) begin
            if (uut.u_wdog.tick)
                ticks++;
            @(negedge sysclk);
            cycles++;
        end
        if (amp_disable == 4'hf) begin
            error_count = error_count + 1;
            $display("Error: amplifiers still held %0d cycles after mv_good rose", cycles);
        end else if ((ticks < SETTLE_TICKS) || (ticks > SETTLE_TICKS + 2)) begin
            error_count = error_count + 1;
            $display("Error at %0t ns: settle hold released after %0d ticks, expected %0d to %0d",
                     $time, ticks, SETTLE_TICKS, SETTLE_TICKS + 2);
        end
        exp_hold = '0;
        check_controls();
        read_check(`REG_STATUS, expected_status(), "STATUS");
        // supply loss holds at once
        mv_good  = 1'b0;
        exp_hold = '1;
        @(negedge sysclk);
        check_controls();
        mv_good = 1'b1;
        repeat ((SETTLE_TICKS + 2) * TICK_CYC) @(negedge sysclk);
        exp_hold = '0;
        check_controls();
    endtask

    task automatic test_wdog_timeout();
        bus_write(`REG_TIMEOUT, 32'd3);
        repeat (8 * TICK_CYC) @(negedge sysclk);     // no host writes
        exp_timeout = 1'b1;
        exp_dis     = 4'hf;
        check_controls();
        read_check(`REG_STATUS, expected_status(), "STATUS");
        status_write(PWR_ON);
        check_controls();
        status_write(amp_word(4'hf, 4'b0101));
        check_controls();
        read_check(`REG_STATUS, expected_status(), "STATUS");
        bus_write(`REG_TIMEOUT, {16'd0, WDOG_PERIOD_RST});
    endtask

    task automatic test_wdog_kick();
        int i;
        bus_write(`REG_TIMEOUT, 32'd3);
        for (i = 0; i < 10; i++) begin
            repeat (2 * TICK_CYC) begin
                @(negedge sysclk);
                check_bit("wdog_timeout", wdog_timeout, 1'b0);
            end
            bus_write(`REG_TIMEOUT, 32'd3);          // kick
        end
        bus_write(`REG_TIMEOUT, 32'd0);              // watchdog off
        repeat (40 * TICK_CYC) begin
            @(negedge sysclk);
            check_bit("wdog_timeout", wdog_timeout, 1'b0);
        end
        bus_write(`REG_TIMEOUT, {16'd0, WDOG_PERIOD_RST});
        check_controls();
    endtask

    task automatic test_safety_latch();
        int         axis;
        axis_mask_t pulse;
        status_write(amp_word(4'hf, 4'hf));
        check_controls();
        axis  = int'($urandom % 4);
        pulse = 4'(1 << axis);
        safety_amp_disable = pulse;
        exp_dis = exp_dis | pulse;
        read_check(`REG_STATUS, expected_status(), "STATUS during safety pulse");
        safety_amp_disable = '0;
        @(negedge sysclk);
        check_controls();
        read_check(`REG_STATUS, expected_status(), "STATUS after safety pulse");
    endtask

    // ----------------------------------------
    // main sequence
    // ----------------------------------------
    initial begin
        void'($urandom(32'h0005_0f50));
        error_count        = 0;
        rst_n              = 1'b0;
        reg_raddr          = '0;
        reg_waddr          = '0;
        reg_wdata          = '0;
        reg_wen            = 1'b0;
        axis_in            = 28'($urandom);
        board_id           = 4'($urandom);
        temp_sense         = 16'($urandom);
        relay              = 1'($urandom);
        mv_faultn          = 1'($urandom);
        mv_good            = 1'b0;
        safety_amp_disable = '0;
        exp_dis            = '1;
        exp_hold           = '1;
        exp_pwr            = 1'b0;
        exp_relay          = 1'b0;
        exp_reboot         = 1'b0;
        exp_timeout        = 1'b0;
        repeat (10) @(posedge sysclk);
        @(negedge sysclk);
        rst_n = 1'b1;

        test_reset_values();
        test_status_control();
        test_mv_settle();         // leaves the supply settled
        test_wdog_timeout();
        test_wdog_kick();
        test_safety_latch();

        $display("tb_board_ctrl finished with %0d errors", error_count);
        if (error_count == 0)
            $display("STATUS: PASS");
        else
            $display("STATUS: FAIL");
        $finish;
    end

endmodule : tb_board_ctrl

`default_nettype wire
